// File: hdl/mipsCfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

`define MIPS_XLEN      32
`define MIPS_NREGS     32
`define MIPS_RESET_PC  32'hbfc0_0000

// primary opcodes, instr[31:26]
`define MIPS_OP_SPECIAL 6'h00
`define MIPS_OP_ADDIU   6'h09
`define MIPS_OP_SLTI    6'h0a
`define MIPS_OP_SLTIU   6'h0b
`define MIPS_OP_ANDI    6'h0c
`define MIPS_OP_ORI     6'h0d
`define MIPS_OP_XORI    6'h0e
`define MIPS_OP_LUI     6'h0f

// funct field of SPECIAL, instr[5:0]
`define MIPS_FN_SLL     6'h00
`define MIPS_FN_SRL     6'h02
`define MIPS_FN_SRA     6'h03
`define MIPS_FN_ADDU    6'h21
`define MIPS_FN_SUBU    6'h23
`define MIPS_FN_AND     6'h24
`define MIPS_FN_OR      6'h25
`define MIPS_FN_XOR     6'h26
`define MIPS_FN_NOR     6'h27
`define MIPS_FN_SLT     6'h2a
`define MIPS_FN_SLTU    6'h2b

`endif

// File: hdl/mipsPkg.sv
`include "mipsCfg.svh"

package mipsPkg;

    typedef logic [`MIPS_XLEN-1:0] word_t;
    typedef logic [$clog2(`MIPS_NREGS)-1:0] regAddr_t;

    typedef enum logic [3:0] {
        ALU_ADDU, ALU_SUBU, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_LUI   // imm placed in the upper half
    } aluOp_t;

    typedef enum logic [1:0] {
        REGFILE, FROM_EX, FROM_WB
    } fwdSel_t;

    typedef struct packed {
        aluOp_t   aluOp;
        logic     useImm;     // opB comes from imm, not rt
        word_t    imm;
        logic [4:0] shamt;
        logic     regWrite;
        regAddr_t writeReg;
    } decodedInst_t;

    typedef struct packed {
        word_t pc;
        logic  valid;
    } ifStage_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
        logic  valid;
    } idStage_t;

    typedef struct packed {
        word_t      pc;
        word_t      opA;
        word_t      opB;
        aluOp_t     aluOp;
        logic [4:0] shamt;
        regAddr_t   writeReg;
        logic       regWrite;
        logic       valid;
    } exStage_t;

    typedef struct packed {
        word_t    pc;
        word_t    result;
        regAddr_t writeReg;
        logic     regWrite;
        logic     valid;
    } wbStage_t;

endpackage

// File: hdl/stageReg.sv
module stageReg
    import mipsPkg::*;
#(
    parameter type payload_t = ifStage_t
) (
    input  logic     clk,
    input  logic     rstN_i,
    input  logic     stall_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // whole payload zeroed so the valid bit drops too
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            q_o <= '0;
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

endmodule

// File: hdl/regFile.sv
`include "mipsCfg.svh"

module regFile
    import mipsPkg::*;
(
    input  logic     clk,
    input  logic     rstN_i,
    input  regAddr_t raddrA_i,
    input  regAddr_t raddrB_i,
    input  regAddr_t waddr_i,
    input  logic     we_i,
    input  word_t    wdata_i,
    output word_t    rdataA_o,
    output word_t    rdataB_o
);

    word_t regs [`MIPS_NREGS];

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin   // $0 stays zero
            regs[waddr_i] <= wdata_i;
        end
    end

    // async read, same-cycle WB value comes through the bypass
    assign rdataA_o = regs[raddrA_i];
    assign rdataB_o = regs[raddrB_i];

endmodule

// File: hdl/instDecoder.sv
`include "mipsCfg.svh"

module instDecoder
    import mipsPkg::*;
(
    input  word_t        instr_i,
    output decodedInst_t dec_o
);

    logic [5:0] opcode;
    logic [5:0] funct;
    regAddr_t   rt;
    regAddr_t   rd;
    word_t      immSext;
    word_t      immZext;

    assign opcode  = instr_i[31:26];
    assign funct   = instr_i[5:0];
    assign rt      = instr_i[20:16];
    assign rd      = instr_i[15:11];
    assign immSext = {{16{instr_i[15]}}, instr_i[15:0]};
    assign immZext = {16'h0000, instr_i[15:0]};

    always_comb begin
        dec_o       = '0;
        dec_o.shamt = instr_i[10:6];
        if (opcode == `MIPS_OP_SPECIAL) begin
            // R-type writes rd
            dec_o.writeReg = rd;
            dec_o.regWrite = 1'b1;
            case (funct)
                `MIPS_FN_ADDU: dec_o.aluOp = ALU_ADDU;
                `MIPS_FN_SUBU: dec_o.aluOp = ALU_SUBU;
                `MIPS_FN_AND:  dec_o.aluOp = ALU_AND;
                `MIPS_FN_OR:   dec_o.aluOp = ALU_OR;
                `MIPS_FN_XOR:  dec_o.aluOp = ALU_XOR;
                `MIPS_FN_NOR:  dec_o.aluOp = ALU_NOR;
                `MIPS_FN_SLT:  dec_o.aluOp = ALU_SLT;
                `MIPS_FN_SLTU: dec_o.aluOp = ALU_SLTU;
                `MIPS_FN_SLL:  dec_o.aluOp = ALU_SLL;
                `MIPS_FN_SRL:  dec_o.aluOp = ALU_SRL;
                `MIPS_FN_SRA:  dec_o.aluOp = ALU_SRA;
                default:       dec_o.regWrite = 1'b0;   // commits as a no-op
            endcase
        end else begin
            dec_o.writeReg = rt;
            dec_o.useImm   = 1'b1;
            dec_o.regWrite = 1'b1;
            dec_o.imm      = immZext;   // logical ops and lui
            case (opcode)
                `MIPS_OP_ADDIU: begin
                    dec_o.aluOp = ALU_ADDU;
                    dec_o.imm   = immSext;
                end
                `MIPS_OP_SLTI: begin
                    dec_o.aluOp = ALU_SLT;
                    dec_o.imm   = immSext;
                end
                `MIPS_OP_SLTIU: begin
                    dec_o.aluOp = ALU_SLTU;
                    dec_o.imm   = immSext;   // sign-extended, compared unsigned
                end
                `MIPS_OP_ANDI: dec_o.aluOp = ALU_AND;
                `MIPS_OP_ORI:  dec_o.aluOp = ALU_OR;
                `MIPS_OP_XORI: dec_o.aluOp = ALU_XOR;
                `MIPS_OP_LUI:  dec_o.aluOp = ALU_LUI;
                default: begin
                    dec_o.regWrite = 1'b0;
                    dec_o.useImm   = 1'b0;
                end
            endcase
        end
    end

endmodule

// File: hdl/bypassNetwork.sv
`include "mipsCfg.svh"

module bypassNetwork
    import mipsPkg::*;
(
    input  regAddr_t rs_i,
    input  regAddr_t rt_i,
    input  word_t    rfA_i,
    input  word_t    rfB_i,
    input  exStage_t ex_i,
    input  word_t    exResult_i,
    input  wbStage_t wb_i,
    output word_t    opA_o,
    output word_t    opB_o
);

    fwdSel_t selA;
    fwdSel_t selB;

    // EX holds the younger producer, so it wins over WB
    function automatic fwdSel_t pickSource(regAddr_t r, exStage_t ex, wbStage_t wb);
        if (r != '0 && ex.valid && ex.regWrite && ex.writeReg == r) begin
            return FROM_EX;
        end else if (r != '0 && wb.valid && wb.regWrite && wb.writeReg == r) begin
            return FROM_WB;
        end
        return REGFILE;
    endfunction

    function automatic logic [`MIPS_XLEN-1:0] muxOperand(fwdSel_t sel, word_t rf,
                                                         word_t exVal, word_t wbVal);
        case (sel)
            FROM_EX: return exVal;
            FROM_WB: return wbVal;
            default: return rf;
        endcase
    endfunction

    always_comb begin
        selA  = pickSource(rs_i, ex_i, wb_i);
        selB  = pickSource(rt_i, ex_i, wb_i);
        opA_o = muxOperand(selA, rfA_i, exResult_i, wb_i.result);
        opB_o = muxOperand(selB, rfB_i, exResult_i, wb_i.result);
    end

endmodule

// File: hdl/alu.sv
`include "mipsCfg.svh"

module alu
    import mipsPkg::*;
(
    input  aluOp_t     op_i,
    input  word_t      a_i,
    input  word_t      b_i,
    input  logic [4:0] shamt_i,
    output word_t      result_o
);

    logic ltSigned;
    logic ltUnsigned;

    assign ltSigned   = $signed(a_i) < $signed(b_i);
    assign ltUnsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            ALU_ADDU: result_o = a_i + b_i;   // wraps, no overflow trap
            ALU_SUBU: result_o = a_i - b_i;
            ALU_AND:  result_o = a_i & b_i;
            ALU_OR:   result_o = a_i | b_i;
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_NOR:  result_o = ~(a_i | b_i);
            ALU_SLT:  result_o = {{(`MIPS_XLEN-1){1'b0}}, ltSigned};
            ALU_SLTU: result_o = {{(`MIPS_XLEN-1){1'b0}}, ltUnsigned};
            // shifts act on rt, which sits in b
            ALU_SLL:  result_o = b_i << shamt_i;
            ALU_SRL:  result_o = b_i >> shamt_i;
            ALU_SRA:  result_o = word_t'($signed(b_i) >>> shamt_i);
            ALU_LUI:  result_o = b_i << 16;
            default:  result_o = '0;
        endcase
    end

endmodule

// File: hdl/mipsCore.sv
`include "mipsCfg.svh"

module mipsCore
    import mipsPkg::*;
(
    input  logic       clk,
    input  logic       rstN_i,
    input  logic       iCacheStall_i,
    input  word_t      instr_i,
    output word_t      pc_o,
    output logic       instEn_o,
    output logic       debugCommit_o,
    output word_t      debugWbPc_o,
    output logic [3:0] debugWbRfWen_o,
    output regAddr_t   debugWbRfWnum_o,
    output word_t      debugWbRfWdata_o
);

    logic         stall;
    logic         rfWe;
    ifStage_t     ifD, ifQ;
    idStage_t     idD, idQ;
    exStage_t     exD, exQ;
    wbStage_t     wbD, wbQ;
    decodedInst_t dec;
    regAddr_t     rs, rt;
    word_t        rfA, rfB;
    word_t        opA, opB;
    word_t        exResult;

    assign stall    = iCacheStall_i;   // only source of back-pressure
    assign instEn_o = rstN_i;

    // IF1, PC register
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            pc_o <= `MIPS_RESET_PC;
        end else if (!stall) begin
            pc_o <= pc_o + word_t'(4);
        end
    end

    always_comb begin
        ifD.pc    = pc_o;
        ifD.valid = instEn_o;
    end

    stageReg #(.payload_t(ifStage_t)) ifStageReg (
        .clk(clk), .rstN_i(rstN_i), .stall_i(stall), .d_i(ifD), .q_o(ifQ)
    );

    // IF2, instruction arrives from memory this cycle
    always_comb begin
        idD.pc    = ifQ.pc;
        idD.instr = ifQ.valid ? instr_i : '0;   // drop stray data
        idD.valid = ifQ.valid;
    end

    stageReg #(.payload_t(idStage_t)) idStageReg (
        .clk(clk), .rstN_i(rstN_i), .stall_i(stall), .d_i(idD), .q_o(idQ)
    );

    // ID
    assign rs = idQ.instr[25:21];
    assign rt = idQ.instr[20:16];

    instDecoder decoder (.instr_i(idQ.instr), .dec_o(dec));

    regFile rf (
        .clk(clk), .rstN_i(rstN_i),
        .raddrA_i(rs), .raddrB_i(rt),
        .waddr_i(wbQ.writeReg), .we_i(rfWe), .wdata_i(wbQ.result),
        .rdataA_o(rfA), .rdataB_o(rfB)
    );

    bypassNetwork bypass (
        .rs_i(rs), .rt_i(rt), .rfA_i(rfA), .rfB_i(rfB),
        .ex_i(exQ), .exResult_i(exResult), .wb_i(wbQ),
        .opA_o(opA), .opB_o(opB)
    );

    always_comb begin
        exD.pc       = idQ.pc;
        exD.opA      = opA;
        exD.opB      = dec.useImm ? dec.imm : opB;
        exD.aluOp    = dec.aluOp;
        exD.shamt    = dec.shamt;
        exD.writeReg = dec.writeReg;
        exD.regWrite = dec.regWrite;
        exD.valid    = idQ.valid;
    end

    stageReg #(.payload_t(exStage_t)) exStageReg (
        .clk(clk), .rstN_i(rstN_i), .stall_i(stall), .d_i(exD), .q_o(exQ)
    );

    // EX
    alu execUnit (
        .op_i(exQ.aluOp), .a_i(exQ.opA), .b_i(exQ.opB),
        .shamt_i(exQ.shamt), .result_o(exResult)
    );

    always_comb begin
        wbD.pc       = exQ.pc;
        wbD.result   = exResult;
        wbD.writeReg = exQ.writeReg;
        wbD.regWrite = exQ.regWrite;
        wbD.valid    = exQ.valid;
    end

    stageReg #(.payload_t(wbStage_t)) wbStageReg (
        .clk(clk), .rstN_i(rstN_i), .stall_i(stall), .d_i(wbD), .q_o(wbQ)
    );

    // WB, register write and commit report
    assign rfWe = wbQ.valid & wbQ.regWrite & ~stall;

    assign debugCommit_o    = wbQ.valid & ~stall;
    assign debugWbRfWen_o   = (rfWe && wbQ.writeReg != '0) ? 4'hf : 4'h0;
    assign debugWbPc_o      = wbQ.pc;
    assign debugWbRfWnum_o  = wbQ.writeReg;
    assign debugWbRfWdata_o = wbQ.result;

endmodule

// File: testbench/tbClock.sv
module tbClock (
    output logic clk_o,
    output logic rstN_o
);

    localparam int RESET_CYCLES = 8;

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;   // period 10
    end

    // release 1 unit after the edge, same as the other inputs
    initial begin
        rstN_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rstN_o = 1'b1;
    end

endmodule

// File: testbench/mipsCoreTb.sv
`include "mipsCfg.svh"

module mipsCoreTb
    import mipsPkg::*;
();

    localparam int PROG_LEN        = 64;
    localparam int WATCHDOG_CYCLES = (PROG_LEN + 8) * 4;
    localparam int CALM_COMMITS    = 16;   // stall-free commits before iCacheStall_i starts

    logic       clk;
    logic       rstN;
    logic       iCacheStall;
    word_t      instr;
    word_t      pc;
    logic       instEn;
    logic       commit;
    word_t      wbPc;
    logic [3:0] wbWen;
    regAddr_t   wbWnum;
    word_t      wbWdata;

    word_t       progMem [PROG_LEN];
    word_t       refRegs [`MIPS_NREGS];
    word_t       pcHist [4];   // pc_o at the last four edges with [3] the oldest
    int          refIdx;
    int          commitCount;
    int          edgeCount;
    logic        stallOn;
    logic [31:0] rngState;
    word_t       expPc;
    word_t       expData;
    logic [3:0]  expWen;
    regAddr_t    expNum;

    tbClock clkGen (.clk_o(clk), .rstN_o(rstN));

    mipsCore dut_i (
        .clk(clk), .rstN_i(rstN), .iCacheStall_i(iCacheStall), .instr_i(instr),
        .pc_o(pc), .instEn_o(instEn), .debugCommit_o(commit), .debugWbPc_o(wbPc),
        .debugWbRfWen_o(wbWen), .debugWbRfWnum_o(wbWnum), .debugWbRfWdata_o(wbWdata)
    );

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // registers 0..7 only, so nearby instructions often depend on each other
    function automatic word_t makeInstr(logic [31:0] a, logic [31:0] b);
        logic [5:0] op;
        logic [5:0] fn;
        int         kind;
        kind = int'(a[7:0]) % 20;
        op   = `MIPS_OP_SPECIAL;
        fn   = 6'h00;
        case (kind)
            0:  fn = `MIPS_FN_ADDU;
            1:  fn = `MIPS_FN_SUBU;
            2:  fn = `MIPS_FN_AND;
            3:  fn = `MIPS_FN_OR;
            4:  fn = `MIPS_FN_XOR;
            5:  fn = `MIPS_FN_NOR;
            6:  fn = `MIPS_FN_SLT;
            7:  fn = `MIPS_FN_SLTU;
            8:  fn = `MIPS_FN_SLL;
            9:  fn = `MIPS_FN_SRL;
            10: fn = `MIPS_FN_SRA;
            11: op = `MIPS_OP_ADDIU;
            12: op = `MIPS_OP_SLTI;
            13: op = `MIPS_OP_SLTIU;
            14: op = `MIPS_OP_ANDI;
            15: op = `MIPS_OP_ORI;
            16: op = `MIPS_OP_XORI;
            17: op = `MIPS_OP_LUI;
            18: fn = 6'h3f;   // unused funct
            default: op = 6'h3f;   // unused opcode
        endcase
        if (op == `MIPS_OP_SPECIAL) begin
            return {op, 2'b00, a[10:8], 2'b00, a[13:11], 2'b00, a[16:14], a[21:17], fn};
        end
        return {op, 2'b00, a[10:8], 2'b00, a[13:11], b[15:0]};
    endfunction

    function automatic word_t fetchWord(word_t addr);
        word_t offset;
        offset = (addr - `MIPS_RESET_PC) >> 2;
        if (offset < PROG_LEN) begin
            return progMem[offset[5:0]];
        end
        return '0;   // sll $0,$0,0 past the program
    endfunction

    // ISA-level model of the next instruction to commit
    task automatic predictCommit();
        word_t      ins;
        word_t      a;
        word_t      b;
        word_t      immS;
        word_t      immZ;
        word_t      res;
        logic [5:0] op;
        logic [4:0] sh;
        regAddr_t   dst;
        logic       writes;
        ins    = (refIdx < PROG_LEN) ? progMem[refIdx] : '0;
        op     = ins[31:26];
        sh     = ins[10:6];
        a      = refRegs[ins[25:21]];
        b      = refRegs[ins[20:16]];
        immS   = {{16{ins[15]}}, ins[15:0]};
        immZ   = {16'h0000, ins[15:0]};
        writes = 1'b1;
        res    = '0;
        dst    = ins[20:16];
        if (op == `MIPS_OP_SPECIAL) begin
            dst = ins[15:11];
            case (ins[5:0])
                `MIPS_FN_ADDU: res = a + b;
                `MIPS_FN_SUBU: res = a - b;
                `MIPS_FN_AND:  res = a & b;
                `MIPS_FN_OR:   res = a | b;
                `MIPS_FN_XOR:  res = a ^ b;
                `MIPS_FN_NOR:  res = ~(a | b);
                `MIPS_FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                `MIPS_FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                `MIPS_FN_SLL:  res = b << sh;
                `MIPS_FN_SRL:  res = b >> sh;
                `MIPS_FN_SRA:  res = $signed(b) >>> sh;
                default:       writes = 1'b0;
            endcase
        end else begin
            case (op)
                `MIPS_OP_ADDIU: res = a + immS;
                `MIPS_OP_SLTI:  res = ($signed(a) < $signed(immS)) ? 32'd1 : 32'd0;
                `MIPS_OP_SLTIU: res = (a < immS) ? 32'd1 : 32'd0;
                `MIPS_OP_ANDI:  res = a & immZ;
                `MIPS_OP_ORI:   res = a | immZ;
                `MIPS_OP_XORI:  res = a ^ immZ;
                `MIPS_OP_LUI:   res = {ins[15:0], 16'h0000};
                default:        writes = 1'b0;
            endcase
        end
        expPc   = `MIPS_RESET_PC + (word_t'(refIdx) << 2);
        expWen  = (writes && dst != '0) ? 4'hf : 4'h0;   // $0 never reported
        expNum  = dst;
        expData = res;
    endtask

    task automatic retireCommit();
        if (expWen != 4'h0) begin
            refRegs[expNum] = expData;
        end
        refIdx++;
        commitCount++;
        predictCommit();
    endtask

    task automatic stopWithFailure();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(string name, word_t got, word_t want);
        $display("ERROR: %s = 0x%08h, expected 0x%08h", name, got, want);
        stopWithFailure();
    endtask

    task automatic reportProblem(string what);
        $display("%s", what);
        stopWithFailure();
    endtask

    // reset state is checked from the second reset edge up to the release edge
    resetPcCheck: assert property (@(posedge clk)
        ((!rstN && edgeCount >= 1) || $rose(rstN)) |-> pc == `MIPS_RESET_PC)
        else reportMismatch("pc_o", $sampled(pc), `MIPS_RESET_PC);
    resetCommitCheck: assert property (@(posedge clk)
        ((!rstN && edgeCount >= 1) || $rose(rstN)) |-> !commit)
        else reportProblem("debugCommit_o was high during or right after reset");
    resetWenCheck: assert property (@(posedge clk)
        ((!rstN && edgeCount >= 1) || $rose(rstN)) |-> wbWen == 4'h0)
        else reportMismatch("debugWbRfWen_o", word_t'($sampled(wbWen)), 32'h0);
    instEnCheck: assert property (@(posedge clk) rstN |-> instEn)
        else reportProblem("instEn_o was low while out of reset");

    commitPcCheck: assert property (@(posedge clk) rstN && commit |-> wbPc == expPc)
        else reportMismatch("debugWbPc_o", $sampled(wbPc), expPc);
    commitWenCheck: assert property (@(posedge clk) rstN && commit |-> wbWen == expWen)
        else reportMismatch("debugWbRfWen_o", word_t'($sampled(wbWen)), word_t'(expWen));
    commitNumCheck: assert property (@(posedge clk)
        rstN && commit && expWen != 4'h0 |-> wbWnum == expNum)
        else reportMismatch("debugWbRfWnum_o", word_t'($sampled(wbWnum)), word_t'(expNum));
    commitDataCheck: assert property (@(posedge clk)
        rstN && commit && expWen != 4'h0 |-> wbWdata == expData)
        else reportMismatch("debugWbRfWdata_o", $sampled(wbWdata), expData);

    // stall-free latency of the fifth instruction, which sits at reset pc + 16
    latencyCheck: assert property (@(posedge clk)
        rstN && !stallOn && pcHist[3] == `MIPS_RESET_PC + 32'd16 |-> commit && wbPc == pcHist[3])
        else reportProblem("fifth instruction did not commit 4 cycles after its fetch");
    backToBackCheck: assert property (@(posedge clk)
        rstN && !stallOn && commitCount >= 5 |-> commit)
        else reportProblem("a commit was missing in a cycle without iCacheStall_i");

    // memory model, stall and reference bookkeeping
    initial begin
        word_t       pcNow;
        logic        commitNow;
        logic        stallNow;
        logic [31:0] r1;
        logic [31:0] r2;
        iCacheStall = 1'b0;
        instr       = '0;
        rngState    = 32'hcf38_4675;
        stallOn     = 1'b0;
        refIdx      = 0;
        commitCount = 0;
        edgeCount   = 0;
        for (int k = 0; k < 4; k++) begin
            pcHist[k] = '0;
        end
        for (int k = 0; k < `MIPS_NREGS; k++) begin
            refRegs[k] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            rngState   = xorshift32(rngState);
            r1         = rngState;
            rngState   = xorshift32(rngState);
            r2         = rngState;
            progMem[i] = makeInstr(r1, r2);
        end
        predictCommit();
        forever begin
            @(posedge clk);
            pcNow     = pc;          // values before the edge updates land
            commitNow = commit;
            stallNow  = iCacheStall;
            #1;
            edgeCount++;
            for (int k = 3; k > 0; k--) begin
                pcHist[k] = pcHist[k-1];
            end
            pcHist[0] = pcNow;
            if (!stallNow) begin
                instr = fetchWord(pcNow);   // holds while stalled
            end
            if (commitNow) begin
                retireCommit();
            end
            if (commitCount >= CALM_COMMITS) begin
                stallOn = 1'b1;
            end
            rngState    = xorshift32(rngState);
            iCacheStall = stallOn && (rngState[1:0] == 2'b00);   // about 1 in 4
        end
    end

    initial begin
        @(posedge rstN);
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        reportProblem($sformatf("timeout with %0d of %0d instructions committed",
                                commitCount, PROG_LEN));
    end

    initial begin
        @(posedge rstN);
        while (commitCount < PROG_LEN) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);   // a few trailing no-ops too
        $display("Verification passed");
        $finish;
    end

endmodule

// File: mipsCore.f
+incdir+hdl
hdl/mipsPkg.sv
hdl/stageReg.sv
hdl/regFile.sv
hdl/instDecoder.sv
hdl/bypassNetwork.sv
hdl/alu.sv
hdl/mipsCore.sv
testbench/tbClock.sv
testbench/mipsCoreTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mipsCoreTb
LOG       ?= sim.log
FILELIST  ?= mipsCore.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= Verification passed

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "overridable: VERILATOR TOP LOG FILELIST BUILD_DIR VFLAGS"

test:
	@rm -f $(LOG)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) > $(LOG) 2>&1
	-./$(BUILD_DIR)/V$(TOP) >> $(LOG) 2>&1
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
